// ==== source/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Operand and result width of the execution unit
`define EX_WORD_WIDTH 32

// Destination register tag, one of 32 architectural registers
`define EX_TAG_WIDTH 5

// Shift amount taken from the low bits of operand b
`define EX_SHAMT_WIDTH 5

// Shift-add or shift-subtract steps per multiply/divide
// One step per result bit
`define EX_MD_ITERATIONS 32

`endif

// ==== source/ex_pkg.sv ====
`include "ex_consts.svh"

package ex_pkg;

  // Operand and result value
  typedef logic [`EX_WORD_WIDTH-1:0] word_t;

  // Destination register tag, carried alongside each request
  typedef logic [`EX_TAG_WIDTH-1:0] tag_t;

  // Operation code
  // Bit 4 marks an M-extension operation
  // Bit 3 selects the alternate base form (sub, sra)
  // Bits 2:0 repeat the RISC-V funct3
  typedef enum logic [4:0] {
    OP_ADD    = 5'b0_0_000,
    OP_SLL    = 5'b0_0_001,
    OP_SLT    = 5'b0_0_010,
    OP_SLTU   = 5'b0_0_011,
    OP_XOR    = 5'b0_0_100,
    OP_SRL    = 5'b0_0_101,
    OP_OR     = 5'b0_0_110,
    OP_AND    = 5'b0_0_111,
    // Alternate forms of add and srl
    OP_SUB    = 5'b0_1_000,
    OP_SRA    = 5'b0_1_101,
    // M extension
    OP_MUL    = 5'b1_0_000,
    OP_MULH   = 5'b1_0_001,
    OP_MULHSU = 5'b1_0_010,
    OP_MULHU  = 5'b1_0_011,
    OP_DIV    = 5'b1_0_100,
    OP_DIVU   = 5'b1_0_101,
    OP_REM    = 5'b1_0_110,
    OP_REMU   = 5'b1_0_111
  } ex_op_e;

endpackage

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::ex_op_e op_i,
  input  ex_pkg::word_t  a_i,
  input  ex_pkg::word_t  b_i,
  output ex_pkg::word_t  result_o
);
  import ex_pkg::*;

  // Shift amount from the low bits of b
  logic [`EX_SHAMT_WIDTH-1:0] shamt;

  // Comparison flags
  logic lt_signed;
  logic lt_unsigned;

  // Adder results
  word_t sum;
  word_t diff;

  // Shifter results
  word_t sll_res;
  word_t srl_res;
  word_t sra_res;

  assign shamt = b_i[`EX_SHAMT_WIDTH-1:0];

  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;

  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  assign sll_res = a_i << shamt;
  assign srl_res = a_i >> shamt;
  // Arithmetic shift keeps the sign bit of a
  assign sra_res = word_t'($signed(a_i) >>> shamt);

  always_comb begin
    case (op_i)
      OP_ADD:  result_o = sum;
      OP_SUB:  result_o = diff;
      OP_SLL:  result_o = sll_res;
      OP_SRL:  result_o = srl_res;
      OP_SRA:  result_o = sra_res;
      // Set-less-than gives 0 or 1 in bit 0
      OP_SLT:  result_o = {{(`EX_WORD_WIDTH-1){1'b0}}, lt_signed};
      OP_SLTU: result_o = {{(`EX_WORD_WIDTH-1){1'b0}}, lt_unsigned};
      OP_XOR:  result_o = a_i ^ b_i;
      OP_OR:   result_o = a_i | b_i;
      OP_AND:  result_o = a_i & b_i;
      // M-extension codes are served by the multiply/divide unit
      default: result_o = '0;
    endcase
  end

endmodule

// ==== source/ex_muldiv.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_muldiv (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           v_i,
  input  ex_pkg::ex_op_e op_i,
  input  ex_pkg::word_t  a_i,
  input  ex_pkg::word_t  b_i,
  input  logic           yumi_i,
  output logic           ready_o,
  output logic           v_o,
  output ex_pkg::word_t  result_o
);
  import ex_pkg::*;

  localparam int word_w = `EX_WORD_WIDTH;
  localparam int cnt_w  = $clog2(`EX_MD_ITERATIONS);

  typedef enum logic [2:0] {
    st_idle, st_setup, st_iter, st_fix, st_done
  } state_e;

  state_e           state_r;
  logic [cnt_w-1:0] cnt_r;

  // Request as accepted, kept for sign handling and corner cases
  ex_op_e op_r;
  word_t  a_r;
  word_t  b_r;

  // Multiplicand or divisor magnitude
  word_t  opnd_r;
  // Product high half or partial remainder
  word_t  hi_r;
  // Multiplier bits or quotient bits
  word_t  lo_r;
  word_t  result_r;

  logic                is_div;
  logic                a_signed;
  logic                b_signed;
  logic                neg_a;
  logic                neg_b;
  logic                neg_res;
  word_t               a_abs;
  word_t               b_abs;
  logic [word_w:0]     add_sum;
  logic [word_w:0]     rem_cand;
  logic [word_w:0]     sub_diff;
  logic [2*word_w-1:0] prod_fix;
  word_t               quot_fix;
  word_t               rem_fix;
  word_t               fix_result;

  // funct3 bit 2 separates divide from multiply
  assign is_div = op_r[2];

  always_comb begin
    case (op_r)
      OP_MUL, OP_MULH, OP_DIV, OP_REM: {a_signed, b_signed} = 2'b11;
      OP_MULHSU:                       {a_signed, b_signed} = 2'b10;
      default:                         {a_signed, b_signed} = 2'b00;
    endcase
  end

  assign neg_a   = a_signed & a_r[word_w-1];
  assign neg_b   = b_signed & b_r[word_w-1];
  assign neg_res = neg_a ^ neg_b;
  assign a_abs   = neg_a ? -a_r : a_r;
  assign b_abs   = neg_b ? -b_r : b_r;

  // One multiply step, add then shift right
  assign add_sum = {1'b0, hi_r} + (lo_r[0] ? {1'b0, opnd_r} : '0);

  // One restoring divide step, shift left then trial subtract
  assign rem_cand = {hi_r, lo_r[word_w-1]};
  assign sub_diff = rem_cand - {1'b0, opnd_r};

  // Restore signs on the magnitudes
  assign prod_fix = neg_res ? -{hi_r, lo_r} : {hi_r, lo_r};
  assign quot_fix = neg_res ? -lo_r : lo_r;
  assign rem_fix  = neg_a ? -hi_r : hi_r;

  always_comb begin
    case (op_r)
      OP_MUL:                    fix_result = prod_fix[word_w-1:0];
      OP_MULH, OP_MULHSU, OP_MULHU: fix_result = prod_fix[2*word_w-1:word_w];
      // Divide by zero gives all ones, overflow falls out of the magnitudes
      OP_DIV, OP_DIVU:           fix_result = (b_r == '0) ? '1 : quot_fix;
      // Remainder of divide by zero is the dividend
      OP_REM, OP_REMU:           fix_result = (b_r == '0) ? a_r : rem_fix;
      default:                   fix_result = '0;
    endcase
  end

  // Control FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        st_idle:  if (v_i) state_r <= st_setup;
        st_setup: begin
          state_r <= st_iter;
          cnt_r   <= '0;
        end
        st_iter: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w'(`EX_MD_ITERATIONS - 1)) state_r <= st_fix;
        end
        st_fix:   state_r <= st_done;
        st_done:  if (yumi_i) state_r <= st_idle;
        default:  state_r <= st_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    case (state_r)
      st_idle: begin
        if (v_i) begin
          op_r <= op_i;
          a_r  <= a_i;
          b_r  <= b_i;
        end
      end
      st_setup: begin
        hi_r   <= '0;
        lo_r   <= is_div ? a_abs : b_abs;
        opnd_r <= is_div ? b_abs : a_abs;
      end
      st_iter: begin
        if (!is_div) begin
          hi_r <= add_sum[word_w:1];
          lo_r <= {add_sum[0], lo_r[word_w-1:1]};
        end else if (!sub_diff[word_w]) begin
          // Divisor fits, keep the difference and set a quotient bit
          hi_r <= sub_diff[word_w-1:0];
          lo_r <= {lo_r[word_w-2:0], 1'b1};
        end else begin
          hi_r <= rem_cand[word_w-1:0];
          lo_r <= {lo_r[word_w-2:0], 1'b0};
        end
      end
      st_fix:  result_r <= fix_result;
      default: ;
    endcase
  end

  assign ready_o  = (state_r == st_idle);
  assign v_o      = (state_r == st_done);
  assign result_o = result_r;

endmodule

// ==== source/ex_issue_retire.sv ====
`timescale 1ns/1ps

module ex_issue_retire (
  // Request side
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  ex_pkg::ex_op_e in_op_i,
  input  ex_pkg::word_t  in_a_i,
  input  ex_pkg::word_t  in_b_i,
  input  ex_pkg::tag_t   in_tag_i,
  // Result side
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output ex_pkg::word_t  out_data_o,
  output ex_pkg::tag_t   out_tag_o,
  // Operation and operands shared by the ALU and multiply/divide unit
  output ex_pkg::ex_op_e ex_op_o,
  output ex_pkg::word_t  ex_a_o,
  output ex_pkg::word_t  ex_b_o,
  // ALU side
  input  ex_pkg::word_t  alu_result_i,
  // Multiply/divide side
  output logic           md_valid_o,
  input  logic           md_ready_i,
  input  logic           md_result_valid_i,
  input  ex_pkg::word_t  md_result_i,
  output logic           md_yumi_o
);
  import ex_pkg::*;

  logic  out_valid_r;
  word_t out_data_r;
  tag_t  out_tag_r;

  // Multiply/divide in flight and the tag it will retire with
  logic  md_busy_r;
  tag_t  pend_tag_r;

  logic  in_is_md;
  logic  out_free;
  logic  accept_alu;

  // Top bit of the operation code marks the M extension
  assign in_is_md = in_op_i[$bits(ex_op_e)-1];

  // Result register empty or draining on this edge
  assign out_free = ~out_valid_r | out_ready_i;

  // Hold off requests while a multiply/divide is in flight
  assign in_ready_o = out_free & ~md_busy_r & md_ready_i;

  assign accept_alu = in_valid_i & in_ready_o & ~in_is_md;
  assign md_valid_o = in_valid_i & in_is_md & out_free & ~md_busy_r;

  // Take the finished result once the result register can hold it
  assign md_yumi_o = md_result_valid_i & out_free;

  assign ex_op_o = in_op_i;
  assign ex_a_o  = in_a_i;
  assign ex_b_o  = in_b_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_r <= 1'b0;
      md_busy_r   <= 1'b0;
    end else begin
      if (md_yumi_o || accept_alu) out_valid_r <= 1'b1;
      else if (out_ready_i)        out_valid_r <= 1'b0;

      if (md_valid_o && md_ready_i) md_busy_r <= 1'b1;
      else if (md_yumi_o)           md_busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (md_valid_o && md_ready_i) pend_tag_r <= in_tag_i;
    // Yumi and ALU accept never coincide, requests are blocked meanwhile
    if (md_yumi_o) begin
      out_data_r <= md_result_i;
      out_tag_r  <= pend_tag_r;
    end else if (accept_alu) begin
      out_data_r <= alu_result_i;
      out_tag_r  <= in_tag_i;
    end
  end

  assign out_valid_o = out_valid_r;
  assign out_data_o  = out_data_r;
  assign out_tag_o   = out_tag_r;

endmodule

// ==== source/ex_unit.sv ====
`timescale 1ns/1ps

module ex_unit (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  ex_pkg::ex_op_e in_op_i,
  input  ex_pkg::word_t  in_a_i,
  input  ex_pkg::word_t  in_b_i,
  input  ex_pkg::tag_t   in_tag_i,
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output ex_pkg::word_t  out_data_o,
  output ex_pkg::tag_t   out_tag_o
);
  import ex_pkg::*;

  // Operation and operands fanned out to both execution blocks
  ex_op_e ex_op;
  word_t  ex_a;
  word_t  ex_b;

  word_t  alu_result;

  // Multiply/divide request and result handshakes
  logic   md_valid;
  logic   md_ready;
  logic   md_result_valid;
  word_t  md_result;
  logic   md_yumi;

  ex_issue_retire u_issue (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .in_valid_i        (in_valid_i),
    .in_ready_o        (in_ready_o),
    .in_op_i           (in_op_i),
    .in_a_i            (in_a_i),
    .in_b_i            (in_b_i),
    .in_tag_i          (in_tag_i),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .out_data_o        (out_data_o),
    .out_tag_o         (out_tag_o),
    .ex_op_o           (ex_op),
    .ex_a_o            (ex_a),
    .ex_b_o            (ex_b),
    .alu_result_i      (alu_result),
    .md_valid_o        (md_valid),
    .md_ready_i        (md_ready),
    .md_result_valid_i (md_result_valid),
    .md_result_i       (md_result),
    .md_yumi_o         (md_yumi)
  );

  // Single-cycle base operations
  ex_alu u_alu (
    .op_i     (ex_op),
    .a_i      (ex_a),
    .b_i      (ex_b),
    .result_o (alu_result)
  );

  // Iterative M-extension operations
  ex_muldiv u_muldiv (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .v_i      (md_valid),
    .op_i     (ex_op),
    .a_i      (ex_a),
    .b_i      (ex_b),
    .yumi_i   (md_yumi),
    .ready_o  (md_ready),
    .v_o      (md_result_valid),
    .result_o (md_result)
  );

endmodule

// ==== verification/tb_ex_unit.sv ====
`timescale 1ns/1ps

module tb_ex_unit;
  import ex_pkg::*;

  localparam int max_reqs      = 64;
  // Worst case per request is a full mul/div plus back-pressure stalls
  localparam int cycles_per_req = 60;

  logic   clk_i;
  logic   rst_n_i;
  logic   in_valid_i;
  logic   in_ready_o;
  ex_op_e in_op_i;
  word_t  in_a_i;
  word_t  in_b_i;
  tag_t   in_tag_i;
  logic   out_valid_o;
  logic   out_ready_i;
  word_t  out_data_o;
  tag_t   out_tag_o;

  // Requests and expected results from the trace
  ex_op_e req_op  [0:max_reqs-1];
  word_t  req_a   [0:max_reqs-1];
  word_t  req_b   [0:max_reqs-1];
  tag_t   req_tag [0:max_reqs-1];
  word_t  req_exp [0:max_reqs-1];
  int     n_req = 0;
  logic   trace_loaded = 1'b0;

  // Results still owed by the DUT, in request order
  word_t  exp_data_q [$];
  tag_t   exp_tag_q  [$];

  logic [31:0] lfsr_r = 32'h100c;
  logic        running = 1'b0;
  int          issue_idx = 0;
  int          accept_idx = 0;
  int          checked_count = 0;
  int          error_count = 0;
  logic        bp_lo;
  logic        bp_hi;
  logic        send_bit;
  logic        alu_wait = 1'b0;
  logic        md_inflight = 1'b0;
  logic        held_valid = 1'b0;
  word_t       held_data;
  tag_t        held_tag;
  word_t       pop_data;
  tag_t        pop_tag;

  ex_unit dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_op_i     (in_op_i),
    .in_a_i      (in_a_i),
    .in_b_i      (in_b_i),
    .in_tag_i    (in_tag_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_tag_o   (out_tag_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit drawn
  function automatic logic next_rand_bit();
    logic lsb;
    lsb    = lfsr_r[0];
    lfsr_r = lfsr_r >> 1;
    if (lsb) lfsr_r = lfsr_r ^ 32'h8020_0003;
    return lsb;
  endfunction

  // Trace mnemonic to operation code, returns 0 for an unknown name
  function automatic bit op_from_name(input logic [63:0] name, output ex_op_e op);
    op_from_name = 1'b1;
    case (name)
      "ADD":    op = OP_ADD;
      "SUB":    op = OP_SUB;
      "SLL":    op = OP_SLL;
      "SLT":    op = OP_SLT;
      "SLTU":   op = OP_SLTU;
      "XOR":    op = OP_XOR;
      "SRL":    op = OP_SRL;
      "SRA":    op = OP_SRA;
      "OR":     op = OP_OR;
      "AND":    op = OP_AND;
      "MUL":    op = OP_MUL;
      "MULH":   op = OP_MULH;
      "MULHSU": op = OP_MULHSU;
      "MULHU":  op = OP_MULHU;
      "DIV":    op = OP_DIV;
      "DIVU":   op = OP_DIVU;
      "REM":    op = OP_REM;
      "REMU":   op = OP_REMU;
      default: begin
        op           = OP_ADD;
        op_from_name = 1'b0;
      end
    endcase
  endfunction

  // M-extension ops go through the iterative unit
  function automatic bit is_mext(input ex_op_e op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
      OP_DIV, OP_DIVU, OP_REM, OP_REMU: return 1'b1;
      default:                          return 1'b0;
    endcase
  endfunction

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          c;
    logic [63:0] tok;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] tag;
    logic [31:0] exp;
    fd = $fopen("verification/ex_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file verification/ex_trace.txt");
      abort_run();
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        // Comment line, skip to its end
        c = $fgetc(fd);
        while (c != "\n" && c != -1) c = $fgetc(fd);
      end else begin
        if (n_req >= max_reqs || !op_from_name(tok, req_op[n_req]) ||
            $fscanf(fd, "%h %h %h %h", a, b, tag, exp) != 4) begin
          $display("Bad or excess trace entry at request %0d", n_req);
          abort_run();
        end
        req_a[n_req]   = a;
        req_b[n_req]   = b;
        req_tag[n_req] = tag_t'(tag);
        req_exp[n_req] = exp;
        n_req++;
      end
    end
    $fclose(fd);
  endtask

  // Main sequence
  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_op_i     = OP_ADD;
    in_a_i      = '0;
    in_b_i      = '0;
    in_tag_i    = '0;
    out_ready_i = 1'b1;
    load_trace();
    trace_loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle state right after reset
    @(posedge clk_i);
    check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
    check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
    @(negedge clk_i);
    running = 1'b1;
    wait (checked_count == n_req);
    repeat (4) @(posedge clk_i);
    if (error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

  // Driver, all random bits drawn here in a fixed order
  always @(posedge clk_i) begin
    if (running) begin
      bp_lo    = next_rand_bit();
      bp_hi    = next_rand_bit();
      send_bit = next_rand_bit();
      // Stall the output about one cycle in four
      out_ready_i <= bp_lo | bp_hi;
      if (in_valid_i && in_ready_o) issue_idx++;
      // Payload may change only when idle or just transferred
      if (!in_valid_i || in_ready_o) begin
        if (issue_idx < n_req && send_bit) begin
          in_valid_i <= 1'b1;
          in_op_i    <= req_op[issue_idx];
          in_a_i     <= req_a[issue_idx];
          in_b_i     <= req_b[issue_idx];
          in_tag_i   <= req_tag[issue_idx];
        end else begin
          in_valid_i <= 1'b0;
        end
      end
    end
  end

  // Monitor and scoreboard
  always @(posedge clk_i) begin
    if (running) begin
      if (held_valid) begin
        check_flag(out_valid_o, 1'b1, "out_valid_o under back-pressure");
        check_word(out_data_o, held_data, "held out_data_o");
        check_tag(out_tag_o, held_tag, "held out_tag_o");
      end
      if (alu_wait) check_flag(out_valid_o, 1'b1, "out_valid_o one cycle after ALU accept");
      if (md_inflight && !out_valid_o) check_flag(in_ready_o, 1'b0, "in_ready_o during mul/div");
      if (out_valid_o) md_inflight = 1'b0;
      held_valid = out_valid_o && !out_ready_i;
      held_data  = out_data_o;
      held_tag   = out_tag_o;
      if (out_valid_o && out_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("A result left the DUT with no request outstanding at %0t ns", $time);
          abort_run();
        end
        pop_data = exp_data_q.pop_front();
        pop_tag  = exp_tag_q.pop_front();
        check_word(out_data_o, pop_data, "out_data_o");
        check_tag(out_tag_o, pop_tag, "out_tag_o");
        checked_count++;
      end
      alu_wait = 1'b0;
      if (in_valid_i && in_ready_o) begin
        exp_data_q.push_back(req_exp[accept_idx]);
        exp_tag_q.push_back(req_tag[accept_idx]);
        if (is_mext(in_op_i)) md_inflight = 1'b1;
        else alu_wait = 1'b1;
        accept_idx++;
      end
    end
  end

  // Watchdog scaled to the trace length
  initial begin
    wait (trace_loaded);
    repeat (n_req * cycles_per_req + 100) @(posedge clk_i);
    $display("Timeout: only %0d of %0d results came back", checked_count, n_req);
    abort_run();
  end

endmodule

// ==== verification/ex_trace.txt ====
# op  operand_a  operand_b  tag  expected_result
# all numbers in hexadecimal, one request per line
ADD    00000005 00000007 01 0000000c
MUL    00000007 00000006 02 0000002a
SUB    00000003 00000005 03 fffffffe
XOR    ff00ff00 0f0f0f0f 04 f00ff00f
DIV    00000014 00000006 05 00000003
SLL    00000001 0000001f 06 80000000
ADD    ffffffff 00000001 07 00000000
MUL    fffffffd 00000004 08 fffffff4
SUB    80000000 00000001 09 7fffffff
SLL    12345678 00000024 0a 23456780
MULH   7fffffff 7fffffff 0b 3fffffff
SRL    80000000 00000004 0c 08000000
SRA    80000000 00000004 0d f8000000
DIV    ffffffec 00000006 0e fffffffd
SRA    f0000000 0000001c 0f ffffffff
SRL    f0000000 0000001c 10 0000000f
MULH   ffffffff ffffffff 11 00000000
SLT    ffffffff 00000001 12 00000001
SLTU   ffffffff 00000001 13 00000000
MULH   80000000 80000000 14 40000000
SLT    00000001 ffffffff 15 00000000
SLTU   00000001 ffffffff 16 00000001
MULHSU ffffffff ffffffff 17 ffffffff
OR     ff00ff00 0f0f0f0f 18 ff0fff0f
MULHU  ffffffff ffffffff 19 fffffffe
AND    ff00ff00 0f0f0f0f 1a 0f000f00
REM    ffffffec 00000006 1b fffffffe
DIVU   ffffffec 00000006 1c 2aaaaaa7
REMU   ffffffec 00000006 1d 00000002
DIV    00000007 00000000 1e ffffffff
REM    00000007 00000000 1f 00000007
DIV    80000000 ffffffff 00 80000000
REM    80000000 ffffffff 01 00000000
REM    00000007 fffffffe 02 00000001
DIV    fffffff9 00000002 03 fffffffd

// ==== sources.f ====
+incdir+source
source/ex_pkg.sv
source/ex_alu.sv
source/ex_muldiv.sv
source/ex_issue_retire.sv
source/ex_unit.sv
verification/tb_ex_unit.sv

// ==== Bender.yml ====
package:
  name: ex_unit

sources:
  - include_dirs:
      - source
    files:
      - source/ex_pkg.sv
      - source/ex_alu.sv
      - source/ex_muldiv.sv
      - source/ex_issue_retire.sv
      - source/ex_unit.sv
      - target: test
        files:
          - verification/tb_ex_unit.sv
